/* riscvCore.f */
logic/cpuPkg.sv
logic/control.sv
logic/alu.sv
logic/regFile.sv
logic/signExtend.sv
logic/pcUnit.sv
logic/riscvCore.sv
bench/coreTb.sv

/* bench/coreTb.sv */
`timescale 1ns/1ps

module coreTb import cpuPkg::*; ();

    localparam logic [31:0] RESET_PC   = 32'h0000_0000;
    localparam logic [31:0] DATA_BASE  = 32'h0000_0100; // data region, 64 words
    localparam int          LAST       = 63;            // index of the final self loop
    localparam int          MAX_CYCLES = 500;

    logic        clk;
    logic        rst;
    logic [31:0] instrAddr;
    logic [31:0] instr;
    logic [31:0] dataRd;
    memReqT      dataReq;

    logic [31:0] imem [0:63];      // program
    logic [31:0] dmem [0:63];      // data seen by the DUT
    logic [31:0] modelMem [0:63];  // data as the model sees it
    logic [31:0] modelRegs [0:31];
    logic [31:0] modelPc;

    int errors;
    int checks;
    int testsRun;
    int testsFailed;

    // both memories read combinationally, word index from address bits 7:2
    assign instr  = imem[instrAddr[7:2]];
    assign dataRd = dmem[dataReq.addr[7:2]];

    always #2 clk = ~clk; // 4 ns period

    // stores land on the rising edge
    always @(posedge clk) begin
        if (dataReq.write) dmem[dataReq.addr[7:2]] <= dataReq.wdata;
    end

    riscvCore #(
        .DATA_WIDTH (32),
        .RESET_PC   (RESET_PC)
    ) dut_i (
        .clk       (clk),
        .rst       (rst),
        .instrAddr (instrAddr),
        .instr     (instr),
        .dataReq   (dataReq),
        .dataRd    (dataRd)
    );

    // instruction encoders, RV32I field layouts
    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_R};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input opcodeT op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE}; // sw
    endfunction

    function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // random program, all control flow forward, x31 kept as data base
    task automatic buildProgram();
        int         kind;
        int         tgt;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        logic [7:0] off;
        logic [7:0] lastOff;
        logic [2:0] f3;
        lastOff = 8'd0;
        imem[0] = iType(DATA_BASE[11:0], 5'd0, 3'b000, 5'd31, OP_IMM); // addi x31, x0, base
        for (int i = 1; i < LAST; i++) begin
            kind = $urandom % 12;
            rs1  = 5'($urandom % 31); // x0..x30, x0 writes included
            rs2  = 5'($urandom % 31);
            rd   = 5'($urandom % 31);
            off  = 8'(($urandom % 64) * 4);
            tgt  = i + 1 + ($urandom % 4);
            if (tgt > LAST) tgt = LAST;
            case ($urandom % 4)
                0:       f3 = 3'b000;
                1:       f3 = 3'b100;
                2:       f3 = 3'b110;
                default: f3 = 3'b111;
            endcase
            case (kind)
                0, 1, 2: begin
                    if (f3 == 3'b000 && $urandom % 2) imem[i] = rType(7'h20, rs2, rs1, f3, rd);
                    else                              imem[i] = rType(7'h00, rs2, rs1, f3, rd);
                end
                3, 4: imem[i] = iType(12'($urandom), rs1, f3, rd, OP_IMM);
                5, 6, 7: begin
                    imem[i] = sType({4'b0, off}, rs2, 5'd31);
                    lastOff = off; // later lw may read it back
                end
                8: begin
                    if ($urandom % 2) off = lastOff;
                    imem[i] = iType({4'b0, off}, 5'd31, 3'b010, rd, OP_LOAD);
                end
                9: begin
                    if ($urandom % 2) rs2 = rs1; // force equal operands
                    imem[i] = bType(13'((tgt - i) * 4), rs2, rs1,
                                    ($urandom % 2) ? 3'b001 : 3'b000);
                end
                10:      imem[i] = jType(21'((tgt - i) * 4), rd);
                default: imem[i] = iType(12'(tgt * 4), 5'd0, 3'b000, rd, OP_JALR); // absolute
            endcase
        end
        imem[LAST] = jType(21'd0, 5'd0); // jal x0, 0
    endtask

    task automatic initMemories();
        logic [31:0] addr;
        for (int i = 0; i < 64; i++) begin
            addr        = DATA_BASE + 32'(i * 4);
            dmem[i]     = ~addr ^ {addr[15:0], addr[31:16]}; // pattern from the full address
            modelMem[i] = ~addr ^ {addr[15:0], addr[31:16]};
        end
        for (int i = 0; i < 32; i++) modelRegs[i] = 32'd0;
        modelPc = RESET_PC;
    endtask

    // executes one instruction of the model, returns the store it expects
    task automatic stepModel(output memReqT exp);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immJ;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] target;
        logic        wr;
        w      = imem[modelPc[7:2]];
        a      = modelRegs[w[19:15]];
        b      = modelRegs[w[24:20]];
        immI   = {{20{w[31]}}, w[31:20]};
        immS   = {{20{w[31]}}, w[31:25], w[11:7]};
        immB   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        immJ   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        wr     = 1'b0;
        res    = 32'd0;
        exp    = '0;
        target = modelPc + 32'd4;
        case (w[6:0])
            OP_R: begin
                wr = 1'b1;
                case ({w[31:25], w[14:12]})
                    {7'h00, 3'b000}: res = a + b;
                    {7'h20, 3'b000}: res = a - b;
                    {7'h00, 3'b100}: res = a ^ b;
                    {7'h00, 3'b110}: res = a | b;
                    {7'h00, 3'b111}: res = a & b;
                    default:         wr  = 1'b0;
                endcase
            end
            OP_IMM: begin
                wr = 1'b1;
                case (w[14:12])
                    3'b000:  res = a + immI;
                    3'b100:  res = a ^ immI;
                    3'b110:  res = a | immI;
                    3'b111:  res = a & immI;
                    default: wr  = 1'b0;
                endcase
            end
            OP_LOAD: begin
                if (w[14:12] == 3'b010) begin
                    addr = a + immI;
                    wr   = 1'b1;
                    res  = modelMem[addr[7:2]];
                end
            end
            OP_STORE: begin
                if (w[14:12] == 3'b010) begin
                    exp.addr  = a + immS;
                    exp.wdata = b;
                    exp.write = 1'b1;
                    modelMem[exp.addr[7:2]] = b;
                end
            end
            OP_BRANCH: begin
                if (w[14:12] == 3'b000 && a == b) target = modelPc + immB; // beq taken
                if (w[14:12] == 3'b001 && a != b) target = modelPc + immB; // bne taken
            end
            OP_JAL: begin
                wr     = 1'b1;
                res    = modelPc + 32'd4;
                target = modelPc + immJ;
            end
            OP_JALR: begin
                if (w[14:12] == 3'b000) begin
                    wr     = 1'b1;
                    res    = modelPc + 32'd4;
                    target = (a + immI) & ~32'd1; // computed before rd changes
                end
            end
            default: ; // anything else is a nop
        endcase
        if (wr && w[11:7] != 5'd0) modelRegs[w[11:7]] = res;
        modelPc = target;
    endtask

    task automatic comparePc(input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL instrAddr got 0x%08h expected 0x%08h", got, exp);
        end
    endtask

    // full compare on a store cycle, only the write bit otherwise
    task automatic compareStore(input memReqT got, input memReqT exp);
        checks++;
        if (exp.write ? (got !== exp) : (got.write !== 1'b0)) begin
            errors++;
            $display("FAIL dataReq addr/wdata/write got %h/%h/%h expected %h/%h/%h",
                     got.addr, got.wdata, got.write, exp.addr, exp.wdata, exp.write);
        end
    endtask

    task automatic reportTest(input string name, input int errs, input int chks);
        testsRun++;
        if (errs != 0) testsFailed++;
        $display("test %s %s, %0d checks, %0d errors", name,
                 (errs == 0) ? "ok" : "failed", chks, errs);
    endtask

    initial begin
        int          errBefore;
        int          chkBefore;
        int          cycles;
        logic        looped;
        logic [31:0] firstWord;
        memReqT      idle;
        memReqT      expReq;
        void'($urandom(17)); // single seed for the whole run
        errors      = 0;
        checks      = 0;
        testsRun    = 0;
        testsFailed = 0;
        clk         = 1'b0;
        rst         = 1'b1;
        idle        = '0;
        buildProgram();
        initMemories();
        firstWord = imem[0];
        imem[0]   = sType(12'd0, 5'd0, 5'd0); // sw at the reset pc, held off by rst

        // reset, no store may leave the core
        errBefore = errors;
        chkBefore = checks;
        repeat (8) begin
            @(negedge clk);
            compareStore(dataReq, idle);
        end
        @(posedge clk);
        rst     <= 1'b0;
        imem[0] <= firstWord; // real program from the first cycle on
        @(negedge clk);
        comparePc(instrAddr, RESET_PC); // first cycle out of reset
        reportTest("reset", errors - errBefore, checks - chkBefore);

        // program run, lockstep with the model, one check pair per cycle
        errBefore = errors;
        chkBefore = checks;
        looped    = 1'b0;
        cycles    = 0;
        while (!looped && cycles < MAX_CYCLES) begin
            comparePc(instrAddr, modelPc);
            if (modelPc == 32'(LAST * 4)) looped = 1'b1;
            stepModel(expReq);
            compareStore(dataReq, expReq);
            cycles++;
            @(negedge clk);
        end
        if (!looped) begin
            errors++;
            $display("program never reached its final loop within %0d cycles", MAX_CYCLES);
        end
        reportTest("program", errors - errBefore, checks - chkBefore);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 testsRun, testsFailed, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* logic/riscvCore.sv */
`timescale 1ns/1ps

module riscvCore import cpuPkg::*; #(
    parameter int          DATA_WIDTH = 32,
    parameter logic [31:0] RESET_PC   = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst,
    output logic [31:0] instrAddr, // fetch address
    input  logic [31:0] instr,     // comb read of instrAddr
    output memReqT      dataReq,
    input  logic [31:0] dataRd     // comb read of dataReq.addr
);

    ctrlT                  ctrl;
    logic [31:0]           pc;
    logic [31:0]           pcPlus4;
    logic [31:0]           imm;
    logic [DATA_WIDTH-1:0] rd1;
    logic [DATA_WIDTH-1:0] rd2;
    logic [DATA_WIDTH-1:0] srcB;       // alu operand b
    logic [DATA_WIDTH-1:0] aluResult;
    logic                  aluZero;
    logic [DATA_WIDTH-1:0] writeBack;  // value headed for rd

    pcUnit #(
        .RESET_PC (RESET_PC)
    ) pcUnit_i (
        .clk       (clk),
        .rst       (rst),
        .sel       (ctrl.pcSel),
        .imm       (imm),
        .aluResult (aluResult),
        .pc        (pc),
        .pcPlus4   (pcPlus4)
    );

    assign instrAddr = pc;

    // decode straight off the fetched word
    control control_i (
        .op     (opcodeT'(instr[6:0])),
        .funct3 (instr[14:12]),
        .funct7 (instr[31:25]),
        .zero   (aluZero),
        .ctrl   (ctrl)
    );

    regFile #(
        .DATA_WIDTH (DATA_WIDTH)
    ) regFile_i (
        .clk       (clk),
        .rst       (rst),
        .rs1       (instr[19:15]),
        .rs2       (instr[24:20]),
        .rd        (instr[11:7]),
        .writeEn   (ctrl.regWrite),
        .writeData (writeBack),
        .rd1       (rd1),
        .rd2       (rd2)
    );

    signExtend signExtend_i (
        .instr (instr),
        .kind  (ctrl.immKind),
        .imm   (imm)
    );

    assign srcB = ctrl.aluSrc ? imm : rd2; // operand mux

    alu #(
        .DATA_WIDTH (DATA_WIDTH)
    ) alu_i (
        .a      (rd1),
        .b      (srcB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    always_comb begin
        case (ctrl.resultSel)
            RES_MEM:  writeBack = dataRd;  // lw
            RES_LINK: writeBack = pcPlus4; // jal / jalr return address
            default:  writeBack = aluResult;
        endcase
    end

    // store request, write held off while in reset
    assign dataReq.addr  = aluResult;
    assign dataReq.wdata = rd2;
    assign dataReq.write = ctrl.memWrite & ~rst;

    // memReqT fields are fixed at 32 bits
    dataWidth32: assert property (@(posedge clk) DATA_WIDTH == 32);

    // fetch address follows the pc choice made by the previous instruction
    pcFollowsPlus4: assert property (@(posedge clk) disable iff (rst)
        ctrl.pcSel == PC_PLUS4 |=> instrAddr == $past(instrAddr) + 32'd4);
    pcFollowsTarget: assert property (@(posedge clk) disable iff (rst)
        ctrl.pcSel == PC_TARGET |=> instrAddr == $past(instrAddr + imm));

endmodule

/* logic/pcUnit.sv */
`timescale 1ns/1ps

module pcUnit import cpuPkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst,
    input  pcSelT       sel,
    input  logic [31:0] imm,       // branch / jal offset
    input  logic [31:0] aluResult, // jalr target
    output logic [31:0] pc,
    output logic [31:0] pcPlus4    // sequential pc, also link value
);

    logic [31:0] pcNext;

    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        case (sel)
            PC_TARGET: pcNext = pc + imm;
            PC_ALU:    pcNext = {aluResult[31:1], 1'b0}; // jalr clears bit 0
            default:   pcNext = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) pc <= RESET_PC;
        else     pc <= pcNext;
    end

    // once running, every fetch address is word aligned
    pcAligned: assert property (@(posedge clk) disable iff (rst)
        !rst |=> pc[1:0] == 2'b00);

endmodule

/* logic/signExtend.sv */
`timescale 1ns/1ps

module signExtend import cpuPkg::*; (
    input  logic [31:0] instr,
    input  immKindT     kind,
    output logic [31:0] imm
);

    always_comb begin
        case (kind)
            IMM_I: imm = {{20{instr[31]}}, instr[31:20]};
            // store offset split over two fields
            IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B: begin
                imm = {{19{instr[31]}}, instr[31], instr[7],
                       instr[30:25], instr[11:8], 1'b0}; // halfword units
            end
            IMM_J: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12],
                       instr[20], instr[30:21], 1'b0};
            end
            default: imm = {{20{instr[31]}}, instr[31:20]}; // treat as I type
        endcase
    end

endmodule

/* logic/regFile.sv */
`timescale 1ns/1ps

module regFile #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [4:0]            rs1,
    input  logic [4:0]            rs2,
    input  logic [4:0]            rd,
    input  logic                  writeEn,
    input  logic [DATA_WIDTH-1:0] writeData,
    output logic [DATA_WIDTH-1:0] rd1,
    output logic [DATA_WIDTH-1:0] rd2
);

    logic [DATA_WIDTH-1:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && rd != 5'd0) begin
            regs[rd] <= writeData; // writes to x0 dropped
        end
    end

    // async reads, x0 always zero
    assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

    // register just written reads back its new value, x0 keeps reading zero
    writeReadBack: assert property (@(posedge clk) disable iff (rst)
        writeEn |=> (rs1 != $past(rd) ||
                     rd1 == (($past(rd) == 5'd0) ? '0 : $past(writeData))));

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps

module alu import cpuPkg::*; #(
    parameter int DATA_WIDTH = 32
) (
    input  logic [DATA_WIDTH-1:0] a,
    input  logic [DATA_WIDTH-1:0] b,
    input  aluOpT                 op,
    output logic [DATA_WIDTH-1:0] result,
    output logic                  zero   // high when result is all zeros
);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b; // also address calc for lw / sw / jalr
            ALU_SUB: result = a - b; // branches compare through this
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            default: result = '0;
        endcase
    end

    // equality flag for beq / bne
    assign zero = (result == '0);

endmodule

/* logic/control.sv */
`timescale 1ns/1ps

module control import cpuPkg::*; (
    input  opcodeT     op,     // opcode field
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    input  logic       zero,   // alu result was zero, i.e. operands equal
    output ctrlT       ctrl
);

    always_comb begin
        // no-operation defaults, anything not decoded below falls through as a nop
        ctrl.regWrite  = 1'b0;
        ctrl.aluOp     = ALU_ADD;
        ctrl.aluSrc    = 1'b0;
        ctrl.memWrite  = 1'b0;
        ctrl.pcSel     = PC_PLUS4;
        ctrl.resultSel = RES_ALU;
        ctrl.immKind   = IMM_I;

        case (op)
            OP_R: begin
                // full funct7 check, only 0000000 and 0100000 are legal here
                if (funct7 == 7'b0000000) begin
                    ctrl.regWrite = 1'b1;
                    case (funct3)
                        3'b000:  ctrl.aluOp = ALU_ADD;
                        3'b100:  ctrl.aluOp = ALU_XOR;
                        3'b110:  ctrl.aluOp = ALU_OR;
                        3'b111:  ctrl.aluOp = ALU_AND;
                        default: ctrl.regWrite = 1'b0; // shifts, compares
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluOp    = ALU_SUB;
                end
            end

            OP_IMM: begin
                // funct7 plays no part, addi is never a subtract
                ctrl.aluSrc   = 1'b1;
                ctrl.immKind  = IMM_I;
                ctrl.regWrite = 1'b1;
                case (funct3)
                    3'b000:  ctrl.aluOp = ALU_ADD; // addi
                    3'b100:  ctrl.aluOp = ALU_XOR; // xori
                    3'b110:  ctrl.aluOp = ALU_OR;  // ori
                    3'b111:  ctrl.aluOp = ALU_AND; // andi
                    default: ctrl.regWrite = 1'b0;
                endcase
            end

            OP_LOAD: begin
                if (funct3 == 3'b010) begin // lw only
                    ctrl.regWrite  = 1'b1;
                    ctrl.aluSrc    = 1'b1; // base + offset
                    ctrl.resultSel = RES_MEM;
                end
            end

            OP_STORE: begin
                if (funct3 == 3'b010) begin // sw only
                    ctrl.memWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                    ctrl.immKind  = IMM_S; // split immediate
                end
            end

            OP_BRANCH: begin
                ctrl.aluOp   = ALU_SUB; // rs1 - rs2, zero means equal
                ctrl.immKind = IMM_B;
                case (funct3)
                    3'b000:  ctrl.pcSel = zero ? PC_TARGET : PC_PLUS4; // beq
                    3'b001:  ctrl.pcSel = zero ? PC_PLUS4 : PC_TARGET; // bne
                    default: ctrl.pcSel = PC_PLUS4;
                endcase
            end

            OP_JAL: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immKind   = IMM_J;
                ctrl.resultSel = RES_LINK;
                ctrl.pcSel     = PC_TARGET;
            end

            OP_JALR: begin
                if (funct3 == 3'b000) begin
                    ctrl.regWrite  = 1'b1;
                    ctrl.aluSrc    = 1'b1; // rs1 + imm computed in alu
                    ctrl.immKind   = IMM_I;
                    ctrl.resultSel = RES_LINK;
                    ctrl.pcSel     = PC_ALU;
                end
            end

            default: ; // keep nop defaults
        endcase
    end

endmodule

/* logic/cpuPkg.sv */
package cpuPkg;

    // major opcodes, RV32I encodings, only the implemented subset
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011, // lw
        OP_IMM    = 7'b0010011, // addi xori ori andi
        OP_STORE  = 7'b0100011, // sw
        OP_R      = 7'b0110011, // add sub xor or and
        OP_BRANCH = 7'b1100011, // beq bne
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcodeT;

    // alu operation select
    typedef enum logic [3:0] {
        ALU_ADD = 4'b0000,
        ALU_SUB = 4'b0001,
        ALU_AND = 4'b0010,
        ALU_OR  = 4'b0011,
        ALU_XOR = 4'b0100
    } aluOpT;

    // immediate format picked by signExtend
    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_J = 3'b011
    } immKindT;

    // next pc source
    typedef enum logic [1:0] {
        PC_PLUS4  = 2'b00, // sequential
        PC_TARGET = 2'b01, // pc + imm, taken branch or jal
        PC_ALU    = 2'b10  // jalr, alu result with bit 0 cleared
    } pcSelT;

    // register writeback source
    typedef enum logic [1:0] {
        RES_ALU  = 2'b00,
        RES_MEM  = 2'b01,
        RES_LINK = 2'b10  // pc + 4 for jal / jalr
    } resultSelT;

    // decoded control bundle, one per instruction
    typedef struct packed {
        logic      regWrite;  // write rd at end of cycle
        aluOpT     aluOp;
        logic      aluSrc;    // 1 = immediate as operand b
        logic      memWrite;  // store
        pcSelT     pcSel;
        resultSelT resultSel;
        immKindT   immKind;
    } ctrlT;

    // data memory request, fixed at 32 bits
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        write;
    } memReqT;

endpackage
